/* Makefile */
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run tb_rv_exec"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -sv -f filelist.f \
		--top-module tb_rv_exec -Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" sim.log || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* common/rv_pkg.sv */
package rv_pkg;

    // major opcodes handled by the slice
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_and  = 3'b111;
    localparam logic [2:0] f3_sra  = 3'b101;
    localparam logic [2:0] f3_sb   = 3'b000;
    localparam logic [2:0] f3_sh   = 3'b001;
    localparam logic [2:0] f3_sw   = 3'b010;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000; // sub, srai

    // inst[31:7] of the two system words
    localparam logic [24:0] sys_ecall  = 25'h000_0000;
    localparam logic [24:0] sys_ebreak = 25'h000_2000;

    typedef enum logic [2:0] {
        cls_i   = 3'b000,
        cls_n   = 3'b001, // ecall / ebreak
        cls_u   = 3'b010,
        cls_r   = 3'b011,
        cls_s   = 3'b100,
        cls_bad = 3'b111
    } inst_class_e;

    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_sltu   = 3'd2,
        alu_and    = 3'd3,
        alu_sra    = 3'd4,
        alu_pass_b = 3'd5  // lui
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // one word, four views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        u_fmt_t u;
    } inst_word_u;

endpackage

/* decode/inst_decode.sv */
`timescale 1ns/1ps

module inst_decode
    import rv_pkg::*;
(
    input  inst_word_u  inst,
    output inst_class_e inst_class,
    output alu_op_e     alu_op,
    output logic [4:0]  rd,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2,
    output logic [31:0] imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst.r.opcode;
    assign funct3 = inst.r.funct3;
    assign funct7 = inst.r.funct7;
    assign rs2    = inst.r.rs2;

    always_comb begin
        inst_class = cls_bad; // anything not matched below
        alu_op     = alu_add;
        rd         = inst.r.rd;
        rs1        = inst.r.rs1;
        case (opcode)
            op_imm: begin
                if (funct3 == f3_add) begin
                    inst_class = cls_i;
                end else if (funct3 == f3_sltu) begin
                    inst_class = cls_i;
                    alu_op     = alu_sltu;
                end else if (funct3 == f3_and) begin
                    inst_class = cls_i;
                    alu_op     = alu_and;
                end else if (funct3 == f3_sra && funct7 == f7_alt) begin
                    inst_class = cls_i;
                    alu_op     = alu_sra;
                end
            end
            op_reg: begin
                if (funct3 == f3_add && funct7 == f7_base) begin
                    inst_class = cls_r;
                end else if (funct3 == f3_add && funct7 == f7_alt) begin
                    inst_class = cls_r;
                    alu_op     = alu_sub;
                end
            end
            op_lui: begin
                inst_class = cls_u;
                alu_op     = alu_pass_b;
                rs1        = 5'd0;
            end
            op_auipc: begin
                inst_class = cls_u; // pc is added in execute
            end
            op_store: begin
                if (funct3 inside {f3_sb, f3_sh, f3_sw}) begin
                    inst_class = cls_s;
                    // no destination for a store, rd carries the access size
                    rd = {2'b00, funct3};
                end
            end
            op_system: begin
                if (inst[31:7] == sys_ecall || inst[31:7] == sys_ebreak)
                    inst_class = cls_n;
            end
            default: inst_class = cls_bad;
        endcase
    end

    // immediate, picked through the matching format view
    always_comb begin
        case (inst_class)
            cls_i, cls_n: imm = {{20{inst.i.imm[11]}}, inst.i.imm}; // ebreak has imm 1
            cls_s:        imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
            cls_u:        imm = {inst.u.imm, 12'b0};
            default:      imm = 32'd0;
        endcase
    end

endmodule

/* filelist.f */
common/rv_pkg.sv
decode/inst_decode.sv
verilog/reg_file.sv
verilog/exec_stage.sv
verilog/rv_exec_top.sv
testbench/exec_checker.sv
testbench/tb_rv_exec.sv

/* testbench/exec_checker.sv */
`timescale 1ns/1ps

module exec_checker
    import rv_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        inst_valid,
    input  logic [31:0] inst,
    input  logic [31:0] pc,
    input  logic        wb_valid,
    input  logic [4:0]  wb_rd,
    input  logic [31:0] wb_data,
    input  logic        store_valid,
    input  logic [31:0] store_addr,
    input  logic [31:0] store_data,
    input  logic [3:0]  store_mask,
    input  logic        ecall_pulse,
    input  logic        ebreak_pulse,
    input  logic        illegal_pulse,
    output int          checks,
    output int          errors
);

    // strobe order {wb, store, ecall, ebreak, illegal}
    localparam logic [4:0] k_none   = 5'b00000;
    localparam logic [4:0] k_wb     = 5'b10000;
    localparam logic [4:0] k_st     = 5'b01000;
    localparam logic [4:0] k_ecall  = 5'b00100;
    localparam logic [4:0] k_ebreak = 5'b00010;
    localparam logic [4:0] k_bad    = 5'b00001;

    logic [31:0] model [32];

    // expectation for the word sampled at the previous edge
    logic        pend;
    logic [4:0]  pend_kind;
    logic [4:0]  pend_rd;
    logic [31:0] pend_data;
    logic [31:0] pend_addr;
    logic [31:0] pend_sdata;
    logic [3:0]  pend_mask;
    logic [31:0] pend_pc;
    logic [31:0] pend_inst;

    function automatic string kind_name(input logic [4:0] k);
        case (k)
            k_none:   return "nothing";
            k_wb:     return "writeback";
            k_st:     return "store";
            k_ecall:  return "ecall";
            k_ebreak: return "ebreak";
            k_bad:    return "illegal";
            default:  return "several strobes";
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("Fail %s: got %h, expected %h (pc %h)", name, got, want, pend_pc);
        end
    endtask

    // outcome of one word against the current register model
    task automatic predict(input logic [31:0] w, input logic [31:0] at_pc,
                           output logic [4:0] kind, output logic [31:0] data,
                           output logic [31:0] addr, output logic [31:0] sdata,
                           output logic [3:0] mask);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] sum;
        a     = model[w[19:15]];
        b     = model[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        sum   = a + imm_s;
        kind  = k_bad;
        data  = 32'd0;
        addr  = {sum[31:2], 2'b00};
        sdata = b;
        mask  = 4'b1111;
        case (w[6:0])
            op_imm: begin
                kind = k_wb;
                case (w[14:12])
                    f3_add:  data = a + imm_i;
                    f3_sltu: data = {31'd0, a < imm_i}; // unsigned compare
                    f3_and:  data = a & imm_i;
                    f3_sra: begin
                        if (w[31:25] == 7'b0100000)
                            data = $signed(a) >>> w[24:20];
                        else
                            kind = k_bad; // srli not supported
                    end
                    default: kind = k_bad;
                endcase
            end
            op_reg: begin
                if (w[14:12] == f3_add && w[31:25] == 7'b0000000) begin
                    kind = k_wb;
                    data = a + b;
                end else if (w[14:12] == f3_add && w[31:25] == 7'b0100000) begin
                    kind = k_wb;
                    data = a - b;
                end
            end
            op_lui: begin
                kind = k_wb;
                data = {w[31:12], 12'd0};
            end
            op_auipc: begin
                kind = k_wb;
                data = at_pc + {w[31:12], 12'd0};
            end
            op_store: begin
                case (w[14:12])
                    f3_sb: begin
                        kind  = k_st;
                        mask  = 4'b0001 << sum[1:0];
                        sdata = {4{b[7:0]}};
                    end
                    f3_sh: begin
                        if (!sum[0]) begin
                            kind  = k_st;
                            mask  = 4'b0011 << sum[1:0];
                            sdata = {2{b[15:0]}};
                        end
                    end
                    f3_sw: begin
                        if (sum[1:0] == 2'b00)
                            kind = k_st;
                    end
                    default: kind = k_bad;
                endcase
            end
            op_system: begin
                if (w == 32'h0000_0073)
                    kind = k_ecall;
                else if (w == 32'h0010_0073)
                    kind = k_ebreak;
            end
            default: kind = k_bad;
        endcase
    endtask

    always @(posedge clk) begin
        logic [4:0]  seen;
        logic [4:0]  want;
        logic [4:0]  kind;
        logic [31:0] data;
        logic [31:0] addr;
        logic [31:0] sdata;
        logic [3:0]  mask;
        int          errs_before;
        if (reset) begin
            for (int r = 0; r < 32; r++)
                model[r] = 32'd0;
            pend   = 1'b0;
            checks = 0;
            errors = 0;
        end else begin
            seen        = {wb_valid, store_valid, ecall_pulse, ebreak_pulse, illegal_pulse};
            want        = pend ? pend_kind : k_none;
            errs_before = errors;
            if (seen !== want) begin
                errors++;
                if (pend)
                    $display("pc %h inst %h: expected %s, the DUT signalled %s",
                             pend_pc, pend_inst, kind_name(want), kind_name(seen));
                else
                    $display("unexpected %s with no instruction presented", kind_name(seen));
            end else if (pend && pend_kind == k_wb) begin
                check_val("wb_rd", 32'(wb_rd), 32'(pend_rd));
                check_val("wb_data", wb_data, pend_data);
            end else if (pend && pend_kind == k_st) begin
                check_val("store_addr", store_addr, pend_addr);
                check_val("store_data", store_data, pend_sdata);
                check_val("store_mask", 32'(store_mask), 32'(pend_mask));
            end
            if (pend) begin
                checks++;
                $display("%s pc %h inst %h %s", (errors == errs_before) ? "ok " : "bad",
                         pend_pc, pend_inst, kind_name(pend_kind));
            end

            // previous writeback is readable by the word sampled now
            if (pend && pend_kind == k_wb && pend_rd != 5'd0)
                model[pend_rd] = pend_data;
            if (inst_valid)
                predict(inst, pc, kind, data, addr, sdata, mask);

            pend       = inst_valid;
            pend_kind  = kind;
            pend_rd    = inst[11:7];
            pend_data  = data;
            pend_addr  = addr;
            pend_sdata = sdata;
            pend_mask  = mask;
            pend_pc    = pc;
            pend_inst  = inst;
        end
    end

endmodule

/* testbench/tb_rv_exec.sv */
`timescale 1ns/1ps

module tb_rv_exec
    import rv_pkg::*;
();

    localparam int          timeout_cycles = 20;
    localparam int          n_random       = 24;
    localparam logic [31:0] lfsr_seed      = 32'h55c8_62eb;

    logic        clk = 1'b0;
    logic        reset;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        store_valid;
    logic [31:0] store_addr;
    logic [31:0] store_data;
    logic [3:0]  store_mask;
    logic        ecall_pulse;
    logic        ebreak_pulse;
    logic        illegal_pulse;
    int          checks;
    int          errors;

    logic [31:0] lfsr;
    logic [31:0] next_pc;
    logic [31:0] tbl_inst [$];
    logic [31:0] tbl_pc [$];

    always #2 clk = ~clk; // 4 ns period

    rv_exec_top i_dut (
        .clk           (clk),
        .reset         (reset),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .pc            (pc),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .store_valid   (store_valid),
        .store_addr    (store_addr),
        .store_data    (store_data),
        .store_mask    (store_mask),
        .ecall_pulse   (ecall_pulse),
        .ebreak_pulse  (ebreak_pulse),
        .illegal_pulse (illegal_pulse)
    );

    exec_checker i_chk (
        .clk           (clk),
        .reset         (reset),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .pc            (pc),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .store_valid   (store_valid),
        .store_addr    (store_addr),
        .store_data    (store_data),
        .store_mask    (store_mask),
        .ecall_pulse   (ecall_pulse),
        .ebreak_pulse  (ebreak_pulse),
        .illegal_pulse (illegal_pulse),
        .checks        (checks),
        .errors        (errors)
    );

    // galois form, taps 32 30 26 25
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = 32'd0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr); // one step per bit
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] imm_word(input int imm, input int rs1,
                                             input logic [2:0] f3, input int rd);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op_imm};
    endfunction

    function automatic logic [31:0] reg_word(input logic [6:0] f7, input int rs2,
                                             input int rs1, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3_add, rd[4:0], op_reg};
    endfunction

    function automatic logic [31:0] store_word(input int imm, input int rs2,
                                               input int rs1, input logic [2:0] f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] upper_word(input int imm, input int rd,
                                               input logic [6:0] op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic logic any_retire();
        return wb_valid | store_valid | ecall_pulse | ebreak_pulse | illegal_pulse;
    endfunction

    task automatic add_entry(input logic [31:0] word);
        tbl_inst.push_back(word);
        tbl_pc.push_back(next_pc);
        next_pc = next_pc + 32'd4;
    endtask

    task automatic build_table();
        add_entry(imm_word(5, 0, f3_add, 1));        // addi x1, x0, 5
        add_entry(imm_word(-3, 0, f3_add, 2));       // addi x2, x0, -3
        add_entry(imm_word(7, 1, f3_sltu, 3));       // sltiu x3, x1, 7
        add_entry(imm_word(-1, 2, f3_sltu, 4));      // sltiu x4, x2, -1
        add_entry(imm_word('h0f0, 2, f3_and, 5));    // andi x5, x2, 0xf0
        add_entry(imm_word('h401, 2, f3_sra, 6));    // srai x6, x2, 1
        add_entry(upper_word('habcde, 7, op_lui));
        add_entry(upper_word(1, 8, op_auipc));
        add_entry(reg_word(7'b0000000, 2, 1, 9));    // add x9, x1, x2
        add_entry(reg_word(7'b0100000, 1, 9, 10));   // sub x10, x9, x1
        add_entry(reg_word(7'b0000000, 10, 10, 11));
        // store operands, base 0x1000 and data 0x12345678
        add_entry(upper_word('h12345, 13, op_lui));
        add_entry(upper_word(1, 12, op_lui));
        add_entry(imm_word('h678, 13, f3_add, 13));
        for (int off = 0; off < 4; off++)
            add_entry(store_word(off, 13, 12, f3_sb));
        add_entry(store_word(0, 13, 12, f3_sh));
        add_entry(store_word(2, 13, 12, f3_sh));
        add_entry(store_word(1, 13, 12, f3_sh));     // misaligned
        add_entry(store_word(4, 13, 12, f3_sw));
        add_entry(store_word(-4, 13, 12, f3_sw));
        add_entry(store_word(2, 13, 12, f3_sw));     // misaligned
        add_entry(32'h0000_0073);                    // ecall
        add_entry(32'h0010_0073);                    // ebreak
        add_entry(32'h0020_0073);                    // unknown system word
        add_entry(32'h0000_006f);                    // jal opcode
        add_entry(imm_word(1, 1, 3'b110, 3));        // ori
        add_entry(imm_word(1, 2, f3_sra, 3));        // srli
        add_entry(reg_word(7'b0000001, 2, 1, 3));    // mul
        add_entry(store_word(0, 13, 12, 3'b011));    // sd
        add_entry(imm_word(9, 1, f3_add, 0));        // addi x0, x1, 9
        add_entry(reg_word(7'b0000000, 0, 0, 14));   // add x14, x0, x0
        add_entry(reg_word(7'b0000000, 0, 0, 15));   // x0 again after the write edge
    endtask

    task automatic add_random();
        int pick;
        int rd;
        int rs1;
        int src;
        for (int n = 0; n < n_random; n++) begin
            pick = take_bits(1);
            rd   = take_bits(5);
            rs1  = take_bits(5);
            if (pick == 1) begin
                src = take_bits(5);
                add_entry(reg_word(7'b0000000, src, rs1, rd));
            end else begin
                src = take_bits(12);
                add_entry(imm_word(src, rs1, f3_add, rd));
            end
        end
    endtask

    initial begin
        int   wait_cnt;
        logic timed_out;
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = 32'd0;
        pc         = 32'd0;
        lfsr       = lfsr_seed;
        next_pc    = 32'h0000_0100;
        timed_out  = 1'b0;
        build_table();
        add_random();
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // outputs idle once reset is released
        wait_cnt = 0;
        @(negedge clk);
        while (any_retire() && wait_cnt < timeout_cycles) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (any_retire()) begin
            $display("timeout: retirement outputs still active after reset release");
            timed_out = 1'b1;
        end

        if (!timed_out) begin
            for (int i = 0; i < tbl_inst.size(); i++) begin
                @(posedge clk);
                inst_valid <= 1'b1;
                inst       <= tbl_inst[i];
                pc         <= tbl_pc[i];
            end
            @(posedge clk);
            inst_valid <= 1'b0;

            wait_cnt = 0;
            @(negedge clk);
            while (checks < tbl_inst.size() && wait_cnt < timeout_cycles) begin
                @(negedge clk);
                wait_cnt++;
            end
            if (checks < tbl_inst.size()) begin
                $display("timeout: the last instruction never retired");
                timed_out = 1'b1;
            end
        end

        $display("%0d instructions checked, %0d errors", checks, errors);
        if (!timed_out && errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verilog/exec_stage.sv */
`timescale 1ns/1ps

module exec_stage
    import rv_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        inst_valid,
    input  logic [31:0] pc,
    input  inst_class_e inst_class,
    input  alu_op_e     alu_op,
    input  logic [4:0]  rd,
    input  logic [31:0] imm,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    output logic        wb_en,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_data,
    output logic        store_valid,
    output logic [31:0] store_addr,
    output logic [31:0] store_data,
    output logic [3:0]  store_mask,
    output logic        ecall_pulse,
    output logic        ebreak_pulse,
    output logic        illegal_pulse
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_res;
    logic [31:0] st_sum;
    logic [2:0]  st_size;
    logic        misaligned;
    logic [31:0] st_data;
    logic [3:0]  st_mask;

    assign op_a = (inst_class == cls_u && alu_op == alu_add) ? pc : rs1_data; // auipc
    assign op_b = (inst_class == cls_r) ? rs2_data : imm;

    always_comb begin
        case (alu_op)
            alu_add:  alu_res = op_a + op_b;
            alu_sub:  alu_res = op_a - op_b;
            alu_sltu: alu_res = {31'd0, op_a < op_b};
            alu_and:  alu_res = op_a & op_b;
            alu_sra:  alu_res = $signed(op_a) >>> op_b[4:0];
            default:  alu_res = op_b; // lui
        endcase
    end

    // store path, size code arrives on rd
    assign st_sum     = rs1_data + imm;
    assign st_size    = rd[2:0];
    assign misaligned = (st_size == f3_sh && st_sum[0]) ||
                        (st_size == f3_sw && st_sum[1:0] != 2'b00);

    always_comb begin
        case (st_size)
            f3_sb: begin
                st_data = {4{rs2_data[7:0]}};
                st_mask = 4'b0001 << st_sum[1:0];
            end
            f3_sh: begin
                st_data = {2{rs2_data[15:0]}};
                st_mask = st_sum[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                st_data = rs2_data;
                st_mask = 4'b1111;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_en         <= 1'b0;
            store_valid   <= 1'b0;
            ecall_pulse   <= 1'b0;
            ebreak_pulse  <= 1'b0;
            illegal_pulse <= 1'b0;
        end else begin
            wb_en         <= inst_valid && inst_class inside {cls_i, cls_u, cls_r};
            store_valid   <= inst_valid && inst_class == cls_s && !misaligned;
            ecall_pulse   <= inst_valid && inst_class == cls_n && !imm[0];
            ebreak_pulse  <= inst_valid && inst_class == cls_n && imm[0];
            illegal_pulse <= inst_valid &&
                             (inst_class == cls_bad || (inst_class == cls_s && misaligned));
        end
    end

    // payload, qualified by the strobes above
    always_ff @(posedge clk) begin
        wb_rd      <= rd;
        wb_data    <= alu_res;
        store_addr <= {st_sum[31:2], 2'b00};
        store_data <= st_data;
        store_mask <= st_mask;
    end

    assert property (@(posedge clk) disable iff (reset)
        inst_valid |=> $onehot({wb_en, store_valid, ecall_pulse, ebreak_pulse, illegal_pulse}))
        else $error("exec_stage: instruction did not retire");

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    input  logic        wb_en,
    input  logic [4:0]  wb_rd,
    input  logic [31:0] wb_data
);

    logic [31:0] regs [32];

    // writeback in flight goes straight to the next reader
    assign rs1_data = (wb_en && wb_rd == rs1 && rs1 != 5'd0) ? wb_data : regs[rs1];
    assign rs2_data = (wb_en && wb_rd == rs2 && rs2 != 5'd0) ? wb_data : regs[rs2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= 32'd0;
        end else if (wb_en && wb_rd != 5'd0) begin
            regs[wb_rd] <= wb_data; // visible to reads next cycle
        end
    end

    // x0 reads as zero through both the array and the bypass
    assert property (@(posedge clk) disable iff (reset)
        (rs1 != 5'd0 || rs1_data == 32'd0) && (rs2 != 5'd0 || rs2_data == 32'd0))
        else $error("reg_file: entry zero modified");

endmodule

/* verilog/rv_exec_top.sv */
`timescale 1ns/1ps

module rv_exec_top
    import rv_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        inst_valid,
    input  logic [31:0] inst,
    input  logic [31:0] pc,
    output logic        wb_valid,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_data,
    output logic        store_valid,
    output logic [31:0] store_addr,
    output logic [31:0] store_data,
    output logic [3:0]  store_mask,
    output logic        ecall_pulse,
    output logic        ebreak_pulse,
    output logic        illegal_pulse
);

    inst_class_e inst_class;
    alu_op_e     alu_op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;

    inst_decode i_decode (
        .inst       (inst),
        .inst_class (inst_class),
        .alu_op     (alu_op),
        .rd         (rd),
        .rs1        (rs1),
        .rs2        (rs2),
        .imm        (imm)
    );

    // writeback loops straight back from the execute registers
    reg_file i_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_en    (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    exec_stage i_exec (
        .clk           (clk),
        .reset         (reset),
        .inst_valid    (inst_valid),
        .pc            (pc),
        .inst_class    (inst_class),
        .alu_op        (alu_op),
        .rd            (rd),
        .imm           (imm),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .wb_en         (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .store_valid   (store_valid),
        .store_addr    (store_addr),
        .store_data    (store_data),
        .store_mask    (store_mask),
        .ecall_pulse   (ecall_pulse),
        .ebreak_pulse  (ebreak_pulse),
        .illegal_pulse (illegal_pulse)
    );

endmodule
